// ==== rob_core.f ====
+incdir+source
+incdir+test
source/isa_pkg.sv
source/rob_pkg.sv
source/rename_table.sv
source/reorder_buffer.sv
source/arch_regfile.sv
source/rob_core.sv
test/tb_rob_core.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the rob_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f rob_core.f --top-module tb_rob_core -o sim_rob_core

out=$(./obj_dir/sim_rob_core)
echo "$out"

if echo "$out" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1

// ==== test/tb_rob_tests.svh ====
task automatic in_order_retirement();
    int errors_before;
    int commits_before;
    errors_before = error_count;
    for (int i = 0; i < 6; i++) begin
        dispatch_one(isa_pkg::KIND_PLAIN, 5'(i + 1), 1'b0);
    end
    // youngest first so nothing leaves until the head is done
    for (int i = 5; i >= 0; i--) begin
        complete_ex(inflight_q[i], $urandom, 1'b0, '0);
        expect_equal("commit_en", 32'(commit_en), 32'(i == 0));
    end
    commits_before = commit_count;
    repeat (6) next_cycle();
    expect_equal("commit count", 32'(commit_count - commits_before), 32'(6));
    wait_drained();
    check_sources(5'd1, 5'd2);
    check_sources(5'd3, 5'd4);
    check_sources(5'd5, 5'd6);
    report("in-order retirement", errors_before);
endtask

task automatic rename_lookup();
    int errors_before;
    errors_before = error_count;
    dispatch_one(isa_pkg::KIND_PLAIN, 5'd7, 1'b0);
    check_sources(5'd7, 5'd0);
    complete_ex(inflight_q[$], $urandom, 1'b0, '0);
    // done but not yet written back
    check_sources(5'd7, 5'd7);
    wait_drained();
    // older commit must not free a newer mapping
    dispatch_one(isa_pkg::KIND_PLAIN, 5'd8, 1'b0);
    dispatch_one(isa_pkg::KIND_PLAIN, 5'd8, 1'b0);
    complete_ex(inflight_q[0], $urandom, 1'b0, '0);
    next_cycle();
    check_sources(5'd8, 5'd7);
    complete_ex(inflight_q[0], $urandom, 1'b0, '0);
    wait_drained();
    check_sources(5'd8, 5'd0);
    report("rename lookup", errors_before);
endtask

task automatic full_backpressure();
    int                errors_before;
    rob_pkg::rob_tag_t pending [$];
    errors_before = error_count;
    for (int i = 0; i < `ROB_DEPTH; i++) begin
        dispatch_one(isa_pkg::KIND_PLAIN, 5'(8 + i), 1'b0);
    end
    expect_equal("full", 32'(full), 32'(1));
    dispatch_en   = 1'b1;
    dispatch_kind = isa_pkg::KIND_PLAIN;
    dispatch_rd   = 5'd24;
    next_cycle();
    dispatch_en = 1'b0;
    check_sources(5'd24, 5'd8);
    expect_equal("full", 32'(full), 32'(1));
    complete_ex(inflight_q[0], $urandom, 1'b0, '0);
    next_cycle();
    expect_equal("full", 32'(full), 32'(0));
    pending = inflight_q;
    foreach (pending[i]) begin
        complete_ex(pending[i], $urandom, 1'b0, '0);
    end
    wait_drained();
    check_sources(5'd8, 5'd23);
    report("full", errors_before);
endtask

task automatic store_retirement();
    int                errors_before;
    rob_pkg::rob_tag_t st;
    rob_pkg::rob_tag_t younger;
    errors_before = error_count;
    dispatch_one(isa_pkg::KIND_STORE, 5'd0, 1'b0);
    dispatch_one(isa_pkg::KIND_PLAIN, 5'd9, 1'b0);
    dispatch_one(isa_pkg::KIND_PLAIN, 5'd10, 1'b0);
    st      = inflight_q[0];
    younger = inflight_q[1];
    // store data and the next result land in the same cycle
    ls_en     = 1'b1;
    ls_tag    = st;
    ls_value  = $urandom;
    ex_en     = 1'b1;
    ex_tag    = younger;
    ex_value  = $urandom;
    ex_taken  = 1'b0;
    ex_target = '0;
    next_cycle();
    ls_en                = 1'b0;
    ex_en                = 1'b0;
    model_done[st]       = 1'b1;
    model_value[st]      = ls_value;
    model_done[younger]  = 1'b1;
    model_value[younger] = ex_value;
    for (int k = 0; k < 4; k++) begin
        expect_equal("store_release_en", 32'(store_release_en), 32'(1));
        expect_equal("store_release_tag", 32'(store_release_tag), 32'(st));
        expect_equal("commit_en", 32'(commit_en), 32'(0));
        if (k == 1) begin
            complete_ex(inflight_q[2], $urandom, 1'b0, '0);
        end else begin
            next_cycle();
        end
    end
    store_ack = 1'b1;
    next_cycle();
    store_ack = 1'b0;
    expect_equal("commit_en", 32'(commit_en), 32'(1));
    wait_drained();
    check_sources(5'd9, 5'd10);
    report("store retirement", errors_before);
endtask

task automatic mispredict_flush();
    int errors_before;
    int flushes_before;
    errors_before = error_count;
    // wrong prediction in both directions
    for (int pd = 0; pd < 2; pd++) begin
        flushes_before = flush_count;
        dispatch_one(isa_pkg::KIND_PLAIN, 5'd11, 1'b0);
        dispatch_one(isa_pkg::KIND_BRANCH, 5'd0, 1'(pd));
        dispatch_one(isa_pkg::KIND_PLAIN, 5'd12, 1'b0);
        dispatch_one(isa_pkg::KIND_PLAIN, 5'd13, 1'b0);
        complete_ex(inflight_q[3], $urandom, 1'b0, '0);
        complete_ex(inflight_q[2], $urandom, 1'b0, '0);
        complete_ex(inflight_q[0], $urandom, 1'b0, '0);
        complete_ex(inflight_q[1], $urandom, 1'(1 - pd), $urandom);
        while (flush_count == flushes_before) begin
            next_cycle();
        end
        check_sources(5'd12, 5'd13);
        check_sources(5'd11, 5'd0);
        expect_equal("full", 32'(full), 32'(0));
    end
    next_cycle();
    report("mispredict flush", errors_before);
endtask

// ==== test/tb_rob_core.sv ====
`timescale 1ns/1ps
`include "rob_macros.svh"

module tb_rob_core;

    localparam int MAX_CYCLES = 2000;

    logic                 clk;
    logic                 rst_n;
    logic                 dispatch_en;
    isa_pkg::instr_kind_t dispatch_kind;
    isa_pkg::reg_name_t   dispatch_rd;
    logic                 dispatch_pd;
    isa_pkg::reg_name_t   src1_reg;
    isa_pkg::reg_name_t   src2_reg;
    logic                 full;
    rob_pkg::rob_tag_t    dispatch_tag;
    logic                 src1_ready;
    rob_pkg::word_t       src1_value;
    rob_pkg::rob_tag_t    src1_tag;
    logic                 src2_ready;
    rob_pkg::word_t       src2_value;
    rob_pkg::rob_tag_t    src2_tag;
    logic                 ex_en;
    rob_pkg::rob_tag_t    ex_tag;
    rob_pkg::word_t       ex_value;
    logic                 ex_taken;
    rob_pkg::pc_t         ex_target;
    logic                 ls_en;
    rob_pkg::rob_tag_t    ls_tag;
    rob_pkg::word_t       ls_value;
    logic                 store_release_en;
    rob_pkg::rob_tag_t    store_release_tag;
    logic                 store_ack;
    logic                 commit_en;
    isa_pkg::reg_name_t   commit_rd;
    rob_pkg::word_t       commit_value;
    rob_pkg::rob_tag_t    commit_tag;
    logic                 flush;
    rob_pkg::pc_t         redirect_pc;

    // reference model of the ROB, rename table and register file
    rob_pkg::word_t       model_regs   [`REG_NUM];
    logic                 model_busy   [`REG_NUM];
    rob_pkg::rob_tag_t    model_prod   [`REG_NUM];
    isa_pkg::instr_kind_t model_kind   [`ROB_DEPTH];
    isa_pkg::reg_name_t   model_rd     [`ROB_DEPTH];
    logic                 model_pd     [`ROB_DEPTH];
    logic                 model_done   [`ROB_DEPTH];
    logic                 model_miss   [`ROB_DEPTH];
    rob_pkg::word_t       model_value  [`ROB_DEPTH];
    rob_pkg::pc_t         model_target [`ROB_DEPTH];
    rob_pkg::rob_tag_t    model_tail;
    rob_pkg::rob_tag_t    inflight_q [$];
    logic                 flush_pending;
    rob_pkg::pc_t         flush_pc;
    int                   cycles;
    int                   check_count;
    int                   error_count;
    int                   commit_count;
    int                   flush_count;
    int                   seed_draw;

    rob_core i_rob_core (.*);

    always #50 clk = ~clk;

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            $display("ERROR at %0t: %s = %0h, expected %0h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic idle_inputs();
        dispatch_en   = 1'b0;
        dispatch_kind = isa_pkg::KIND_PLAIN;
        dispatch_rd   = '0;
        dispatch_pd   = 1'b0;
        src1_reg      = '0;
        src2_reg      = '0;
        ex_en         = 1'b0;
        ex_tag        = '0;
        ex_value      = '0;
        ex_taken      = 1'b0;
        ex_target     = '0;
        ls_en         = 1'b0;
        ls_tag        = '0;
        ls_value      = '0;
        store_ack     = 1'b0;
    endtask

    // flush drops in-flight state but keeps committed registers
    task automatic clear_model();
        for (int i = 0; i < `REG_NUM; i++) begin
            model_busy[i] = 1'b0;
        end
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            model_done[i] = 1'b0;
        end
        inflight_q.delete();
        model_tail = '0;
    endtask

    task automatic record_commit();
        rob_pkg::rob_tag_t tag;
        check_count++;
        assert (inflight_q.size() != 0) else begin
            $display("ERROR at %0t: commit with no instruction in flight", $time);
            error_count++;
        end
        if (inflight_q.size() != 0) begin
            tag = inflight_q.pop_front();
            expect_equal("commit_tag", 32'(commit_tag), 32'(tag));
            expect_equal("commit_rd", 32'(commit_rd), 32'(model_rd[tag]));
            expect_equal("commit_value", commit_value, model_value[tag]);
            check_count++;
            assert (model_done[tag] && model_kind[tag] != isa_pkg::KIND_STORE) else begin
                $display("ERROR at %0t: entry %0d committed before completion or as a store",
                         $time, tag);
                error_count++;
            end
            if (model_rd[tag] != '0) begin
                model_regs[model_rd[tag]] = model_value[tag];
            end
            if (model_busy[model_rd[tag]] && model_prod[model_rd[tag]] == tag) begin
                model_busy[model_rd[tag]] = 1'b0;
            end
            flush_pending = model_miss[tag];
            flush_pc      = model_target[tag];
            commit_count++;
        end
    endtask

    task automatic record_store();
        rob_pkg::rob_tag_t tag;
        tag = inflight_q.pop_front();
        expect_equal("store_release_tag", 32'(store_release_tag), 32'(tag));
        expect_equal("store kind", 32'(model_kind[tag]), 32'(isa_pkg::KIND_STORE));
    endtask

    // outputs are settled at the falling edge
    task automatic watch_retirement();
        forever begin
            @(negedge clk);
            expect_equal("flush", 32'(flush), 32'(flush_pending));
            if (flush) begin
                expect_equal("redirect_pc", redirect_pc, flush_pc);
                clear_model();
                flush_count++;
            end
            flush_pending = 1'b0;
            if (commit_en) begin
                record_commit();
            end
            if (store_release_en && store_ack) begin
                record_store();
            end
        end
    endtask

    task automatic check_one_source(input string name, input isa_pkg::reg_name_t r,
                                    input logic ready, input rob_pkg::word_t value,
                                    input rob_pkg::rob_tag_t tag);
        logic           exp_ready;
        rob_pkg::word_t exp_value;
        exp_ready = !model_busy[r] || model_done[model_prod[r]];
        exp_value = model_busy[r] ? model_value[model_prod[r]] : model_regs[r];
        expect_equal({name, "_ready"}, 32'(ready), 32'(exp_ready));
        if (exp_ready) begin
            expect_equal({name, "_value"}, value, exp_value);
        end else begin
            expect_equal({name, "_tag"}, 32'(tag), 32'(model_prod[r]));
        end
    endtask

    task automatic check_sources(input isa_pkg::reg_name_t r1, input isa_pkg::reg_name_t r2);
        src1_reg = r1;
        src2_reg = r2;
        #1;
        check_one_source("src1", r1, src1_ready, src1_value, src1_tag);
        check_one_source("src2", r2, src2_ready, src2_value, src2_tag);
        next_cycle();
    endtask

    task automatic dispatch_one(input isa_pkg::instr_kind_t kind, input isa_pkg::reg_name_t rd,
                                input logic pd);
        rob_pkg::rob_tag_t tag;
        dispatch_en   = 1'b1;
        dispatch_kind = kind;
        dispatch_rd   = rd;
        dispatch_pd   = pd;
        #1;
        expect_equal("full", 32'(full), 32'(0));
        expect_equal("dispatch_tag", 32'(dispatch_tag), 32'(model_tail));
        next_cycle();
        dispatch_en      = 1'b0;
        tag              = model_tail;
        model_kind[tag]  = kind;
        model_rd[tag]    = rd;
        model_pd[tag]    = pd;
        model_done[tag]  = 1'b0;
        model_miss[tag]  = 1'b0;
        if (rd != '0) begin
            model_busy[rd] = 1'b1;
            model_prod[rd] = tag;
        end
        inflight_q.push_back(tag);
        model_tail++;
    endtask

    task automatic complete_ex(input rob_pkg::rob_tag_t tag, input rob_pkg::word_t value,
                               input logic taken, input rob_pkg::pc_t target);
        ex_en     = 1'b1;
        ex_tag    = tag;
        ex_value  = value;
        ex_taken  = taken;
        ex_target = target;
        next_cycle();
        ex_en             = 1'b0;
        model_done[tag]   = 1'b1;
        model_value[tag]  = value;
        model_target[tag] = target;
        model_miss[tag]   = (model_kind[tag] == isa_pkg::KIND_BRANCH) && (taken != model_pd[tag]);
    endtask

    task automatic wait_drained();
        while (inflight_q.size() != 0) begin
            next_cycle();
        end
    endtask

    task automatic report(input string name, input int errors_before);
        if (error_count == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d error(s)", name, error_count - errors_before);
        end
    endtask

    `include "tb_rob_tests.svh"

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Checks failed");
        $finish;
    end

    initial begin
        seed_draw     = $urandom(99057);
        clk           = 1'b0;
        rst_n         = 1'b0;
        check_count   = 0;
        error_count   = 0;
        commit_count  = 0;
        flush_count   = 0;
        flush_pending = 1'b0;
        flush_pc      = '0;
        idle_inputs();
        for (int i = 0; i < `REG_NUM; i++) begin
            model_regs[i] = '0;
        end
        clear_model();
        repeat (4) @(posedge clk);
        #5;
        rst_n = 1'b1;
        fork
            watch_retirement();
        join_none
        expect_equal("full", 32'(full), 32'(0));
        expect_equal("commit_en", 32'(commit_en), 32'(0));
        expect_equal("store_release_en", 32'(store_release_en), 32'(0));
        in_order_retirement();
        rename_lookup();
        full_backpressure();
        store_retirement();
        mispredict_flush();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== source/rob_core.sv ====
`timescale 1ns/1ps

module rob_core (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 dispatch_en,
    input  isa_pkg::instr_kind_t dispatch_kind,
    input  isa_pkg::reg_name_t   dispatch_rd,
    input  logic                 dispatch_pd,
    input  isa_pkg::reg_name_t   src1_reg,
    input  isa_pkg::reg_name_t   src2_reg,
    output logic                 full,
    output rob_pkg::rob_tag_t    dispatch_tag,
    output logic                 src1_ready,
    output rob_pkg::word_t       src1_value,
    output rob_pkg::rob_tag_t    src1_tag,
    output logic                 src2_ready,
    output rob_pkg::word_t       src2_value,
    output rob_pkg::rob_tag_t    src2_tag,
    input  logic                 ex_en,
    input  rob_pkg::rob_tag_t    ex_tag,
    input  rob_pkg::word_t       ex_value,
    input  logic                 ex_taken,
    input  rob_pkg::pc_t         ex_target,
    input  logic                 ls_en,
    input  rob_pkg::rob_tag_t    ls_tag,
    input  rob_pkg::word_t       ls_value,
    output logic                 store_release_en,
    output rob_pkg::rob_tag_t    store_release_tag,
    input  logic                 store_ack,
    output logic                 commit_en,
    output isa_pkg::reg_name_t   commit_rd,
    output rob_pkg::word_t       commit_value,
    output rob_pkg::rob_tag_t    commit_tag,
    output logic                 flush,
    output rob_pkg::pc_t         redirect_pc
);

    logic           alloc_en;
    logic           src1_busy;
    logic           src2_busy;
    logic           src1_done;
    logic           src2_done;
    rob_pkg::word_t rob1_value;
    rob_pkg::word_t rob2_value;
    rob_pkg::word_t rf1_value;
    rob_pkg::word_t rf2_value;

    reorder_buffer i_reorder_buffer (
        .clk               (clk),
        .rst_n             (rst_n),
        .dispatch_en       (dispatch_en),
        .dispatch_kind     (dispatch_kind),
        .dispatch_rd       (dispatch_rd),
        .dispatch_pd       (dispatch_pd),
        .full              (full),
        .alloc_en          (alloc_en),
        .alloc_tag         (dispatch_tag),
        .ex_en             (ex_en),
        .ex_taken          (ex_taken),
        .ex_tag            (ex_tag),
        .ex_value          (ex_value),
        .ex_target         (ex_target),
        .ls_en             (ls_en),
        .ls_tag            (ls_tag),
        .ls_value          (ls_value),
        .query1_tag        (src1_tag),
        .query2_tag        (src2_tag),
        .query1_done       (src1_done),
        .query2_done       (src2_done),
        .query1_value      (rob1_value),
        .query2_value      (rob2_value),
        .store_release_en  (store_release_en),
        .store_release_tag (store_release_tag),
        .store_ack         (store_ack),
        .commit_en         (commit_en),
        .commit_rd         (commit_rd),
        .commit_value      (commit_value),
        .commit_tag        (commit_tag),
        .flush             (flush),
        .redirect_pc       (redirect_pc)
    );

    rename_table i_rename_table (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .alloc_en   (alloc_en),
        .alloc_reg  (dispatch_rd),
        .alloc_tag  (dispatch_tag),
        .retire_en  (commit_en),
        .retire_reg (commit_rd),
        .retire_tag (commit_tag),
        .src1_reg   (src1_reg),
        .src2_reg   (src2_reg),
        .src1_busy  (src1_busy),
        .src2_busy  (src2_busy),
        .src1_tag   (src1_tag),
        .src2_tag   (src2_tag)
    );

    arch_regfile i_arch_regfile (
        .clk         (clk),
        .rst_n       (rst_n),
        .write_en    (commit_en),
        .write_reg   (commit_rd),
        .write_value (commit_value),
        .read1_reg   (src1_reg),
        .read2_reg   (src2_reg),
        .read1_value (rf1_value),
        .read2_value (rf2_value)
    );

    // no producer: regfile, done producer: ROB, else wait on tag
    assign src1_ready = !src1_busy || src1_done;
    assign src2_ready = !src2_busy || src2_done;
    assign src1_value = src1_busy ? rob1_value : rf1_value;
    assign src2_value = src2_busy ? rob2_value : rf2_value;

endmodule

// ==== source/arch_regfile.sv ====
`timescale 1ns/1ps
`include "rob_macros.svh"

module arch_regfile (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               write_en,
    input  isa_pkg::reg_name_t write_reg,
    input  rob_pkg::word_t     write_value,
    input  isa_pkg::reg_name_t read1_reg,
    input  isa_pkg::reg_name_t read2_reg,
    output rob_pkg::word_t     read1_value,
    output rob_pkg::word_t     read2_value
);

    rob_pkg::word_t regs [`REG_NUM];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && (write_reg != '0)) begin
            // x0 stays zero
            regs[write_reg] <= write_value;
        end
    end

    // same-cycle write not visible here, ROB still holds it
    assign read1_value = regs[read1_reg];
    assign read2_value = regs[read2_reg];

endmodule

// ==== source/reorder_buffer.sv ====
`timescale 1ns/1ps
`include "rob_macros.svh"

module reorder_buffer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 dispatch_en,
    input  isa_pkg::instr_kind_t dispatch_kind,
    input  isa_pkg::reg_name_t   dispatch_rd,
    input  logic                 dispatch_pd,
    output logic                 full,
    output logic                 alloc_en,
    output rob_pkg::rob_tag_t    alloc_tag,
    input  logic                 ex_en,
    input  logic                 ex_taken,
    input  rob_pkg::rob_tag_t    ex_tag,
    input  rob_pkg::word_t       ex_value,
    input  rob_pkg::pc_t         ex_target,
    input  logic                 ls_en,
    input  rob_pkg::rob_tag_t    ls_tag,
    input  rob_pkg::word_t       ls_value,
    input  rob_pkg::rob_tag_t    query1_tag,
    input  rob_pkg::rob_tag_t    query2_tag,
    output logic                 query1_done,
    output logic                 query2_done,
    output rob_pkg::word_t       query1_value,
    output rob_pkg::word_t       query2_value,
    output logic                 store_release_en,
    output rob_pkg::rob_tag_t    store_release_tag,
    input  logic                 store_ack,
    output logic                 commit_en,
    output isa_pkg::reg_name_t   commit_rd,
    output rob_pkg::word_t       commit_value,
    output rob_pkg::rob_tag_t    commit_tag,
    output logic                 flush,
    output rob_pkg::pc_t         redirect_pc
);

    rob_pkg::entry_state_t state  [`ROB_DEPTH];
    isa_pkg::instr_kind_t  kind   [`ROB_DEPTH];
    isa_pkg::reg_name_t    rd     [`ROB_DEPTH];
    logic                  pd     [`ROB_DEPTH];
    logic                  taken  [`ROB_DEPTH];
    rob_pkg::word_t        value  [`ROB_DEPTH];
    rob_pkg::pc_t          target [`ROB_DEPTH];

    rob_pkg::rob_tag_t head;
    rob_pkg::rob_tag_t tail;
    logic [`TAG_W:0]   count;

    logic ex_hit;
    logic ls_hit;
    logic head_done;
    logic head_store;
    logic retire;
    logic mispredict;

    assign full      = (count == (`TAG_W+1)'(`ROB_DEPTH));
    assign alloc_en  = dispatch_en && !full && !flush;
    assign alloc_tag = tail;

    // completions only land on issued entries
    assign ex_hit = ex_en && (state[ex_tag] == rob_pkg::ST_ISSUED);
    assign ls_hit = ls_en && (state[ls_tag] == rob_pkg::ST_ISSUED);

    assign query1_done  = (state[query1_tag] == rob_pkg::ST_DONE);
    assign query2_done  = (state[query2_tag] == rob_pkg::ST_DONE);
    assign query1_value = value[query1_tag];
    assign query2_value = value[query2_tag];

    // head retirement, nothing leaves during the flush cycle
    assign head_done  = (state[head] == rob_pkg::ST_DONE);
    assign head_store = (kind[head] == isa_pkg::KIND_STORE);

    assign commit_en    = head_done && !head_store && !flush;
    assign commit_rd    = rd[head];
    assign commit_value = value[head];
    assign commit_tag   = head;

    assign store_release_en  = head_done && head_store && !flush;
    assign store_release_tag = head;

    // store waits at the head for its ack
    assign retire = commit_en || (store_release_en && store_ack);

    assign mispredict = commit_en && (kind[head] == isa_pkg::KIND_BRANCH)
                        && (taken[head] != pd[head]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                state[i] <= rob_pkg::ST_FREE;
            end
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            flush       <= 1'b0;
            redirect_pc <= '0;
        end else if (flush) begin
            // drop everything younger than the mispredicted branch
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                state[i] <= rob_pkg::ST_FREE;
            end
            head  <= '0;
            tail  <= '0;
            count <= '0;
            flush <= 1'b0;
        end else begin
            flush <= mispredict;
            if (mispredict) begin
                redirect_pc <= target[head];
            end
            if (alloc_en) begin
                state[tail] <= rob_pkg::ST_ISSUED;
                tail        <= tail + 1'b1;
            end
            if (ex_hit) begin
                state[ex_tag] <= rob_pkg::ST_DONE;
            end
            if (ls_hit) begin
                state[ls_tag] <= rob_pkg::ST_DONE;
            end
            if (retire) begin
                state[head] <= rob_pkg::ST_FREE;
                head        <= head + 1'b1;
            end
            case ({alloc_en, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (alloc_en) begin
            kind[tail] <= dispatch_kind;
            rd[tail]   <= dispatch_rd;
            pd[tail]   <= dispatch_pd;
        end
        if (ex_hit) begin
            value[ex_tag]  <= ex_value;
            taken[ex_tag]  <= ex_taken;
            target[ex_tag] <= ex_target;
        end
        // store address and data ready
        if (ls_hit) begin
            value[ls_tag] <= ls_value;
        end
    end

endmodule

// ==== source/rename_table.sv ====
`timescale 1ns/1ps
`include "rob_macros.svh"

module rename_table (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush,
    input  logic               alloc_en,
    input  isa_pkg::reg_name_t alloc_reg,
    input  rob_pkg::rob_tag_t  alloc_tag,
    input  logic               retire_en,
    input  isa_pkg::reg_name_t retire_reg,
    input  rob_pkg::rob_tag_t  retire_tag,
    input  isa_pkg::reg_name_t src1_reg,
    input  isa_pkg::reg_name_t src2_reg,
    output logic               src1_busy,
    output logic               src2_busy,
    output rob_pkg::rob_tag_t  src1_tag,
    output rob_pkg::rob_tag_t  src2_tag
);

    logic              busy     [`REG_NUM];
    rob_pkg::rob_tag_t prod_tag [`REG_NUM];
    logic              alloc_live;
    logic              retire_hit;

    // x0 never gets a producer
    assign alloc_live = alloc_en && (alloc_reg != '0);

    // only the newest producer may release the mapping
    assign retire_hit = retire_en && busy[retire_reg] && (prod_tag[retire_reg] == retire_tag);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                busy[i] <= 1'b0;
            end
        end else if (flush) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                busy[i] <= 1'b0;
            end
        end else begin
            if (retire_hit) begin
                busy[retire_reg] <= 1'b0;
            end
            // a same-cycle dispatch overrides the release
            if (alloc_live) begin
                busy[alloc_reg] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_live) begin
            prod_tag[alloc_reg] <= alloc_tag;
        end
    end

    assign src1_busy = busy[src1_reg];
    assign src2_busy = busy[src2_reg];
    assign src1_tag  = prod_tag[src1_reg];
    assign src2_tag  = prod_tag[src2_reg];

endmodule

// ==== source/rob_pkg.sv ====
`include "rob_macros.svh"

package rob_pkg;

    // entry index, doubles as the rename tag
    typedef logic [`TAG_W-1:0] rob_tag_t;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [`XLEN-1:0] pc_t;

    // entry lifecycle
    typedef enum logic [1:0] {
        ST_FREE   = 2'd0,
        ST_ISSUED = 2'd1,
        ST_DONE   = 2'd2
    } entry_state_t;

endpackage

// ==== source/isa_pkg.sv ====
package isa_pkg;

    // architectural register name, x0..x31
    typedef logic [4:0] reg_name_t;

    // what retirement has to do with an entry
    typedef enum logic [1:0] {
        KIND_PLAIN  = 2'd0,
        KIND_STORE  = 2'd1,
        KIND_BRANCH = 2'd2
    } instr_kind_t;

endpackage

// ==== source/rob_macros.svh ====
`ifndef ROB_MACROS_SVH
`define ROB_MACROS_SVH

// reorder buffer sizing
// ROB_DEPTH must stay a power of two so the pointers wrap on their own
`define ROB_DEPTH 16
`define TAG_W     4

// datapath widths
`define XLEN      32

// architectural register count
`define REG_NUM   32

`endif
